/* dv/tb_vp_support.sv */
`timescale 1ns/1ps

module tb_vp_support;

	localparam int PERIOD = 40;
	// Downloads dominate the run time
	localparam int RUN_CYCLES = 4096 + 8192 + 16384 + 4096 + 256 + 2000;
	localparam int TIMEOUT_NS = 2 * RUN_CYCLES * PERIOD;

	localparam logic [23:0] NTSC_COLORS [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6, 24'h006d07, 24'h56c469,
		24'h2aaabe, 24'h77e6eb, 24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};
	localparam logic [23:0] PAL_COLORS [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff, 24'h00b601, 24'h49ff49,
		24'h00b6c9, 24'h49ffff, 24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	logic                clk_sys;
	logic                reset;
	logic                pal_i;
	logic                palette_pal_i;
	logic                dl_active_i;
	logic                dl_wr_i;
	vp_pkg::load_index_e dl_index_i;
	logic [13:0]         dl_addr_i;
	logic [7:0]          dl_data_i;
	logic [11:0]         cart_addr_i;
	logic                cart_bank0_i;
	logic                cart_bank1_i;
	logic                cart_rd_n_i;
	logic [10:0]         ps2_key_i;
	vp_pkg::joy_t        joystick_0_i;
	vp_pkg::joy_t        joystick_1_i;
	logic                joy_swap_i;
	logic [3:0]          rgbl_i;
	logic                cpu_en_o;
	logic                vdc_en_o;
	logic [7:0]          cart_data_o;
	logic                key_valid_o;
	logic [7:0]          key_ascii_o;
	logic                key_released_o;
	logic [1:0]          joy_up_n_o;
	logic [1:0]          joy_down_n_o;
	logic [1:0]          joy_left_n_o;
	logic [1:0]          joy_right_n_o;
	logic [1:0]          joy_action_n_o;
	logic                joy_reset_n_o;
	logic [23:0]         color_o;

	logic [7:0]  rom_model [0:16383]; // Expected cartridge ROM contents
	logic [31:0] lfsr_state;

	vp_support_top vp_support_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped by the watchdog");
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// Taps 32, 22, 2, 1
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[14:0], fb};
		end
		return value;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk_sys);
		reset = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	endtask

	// ROM byte that a console address reaches for each map mode
	function automatic int mapped_addr(input vp_pkg::cart_map_e mode, input int addr,
		input logic b0, input logic b1);
		int low;
		low = (addr & 'h3ff) + ((addr >> 11) & 1) * 1024; // A10 skipped
		case (mode)
			vp_pkg::MAP_XROM: return addr;
			vp_pkg::MAP_4K:   return int'(b0) * 2048 + low;
			vp_pkg::MAP_8K:   return int'(b1) * 4096 + int'(b0) * 2048 + low;
			vp_pkg::MAP_16K:  return int'(b1) * 8192 + int'(b0) * 4096 + addr;
			default:          return low;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic test_enables(input logic pal, input int cpu_div, input int vdc_div);
		@(negedge clk_sys);
		pal_i = pal;
		apply_reset();
		for (int c = 1; c <= 3 * cpu_div; c++) begin
			@(negedge clk_sys);
			check_value("cpu_en_o", 32'(cpu_en_o), 32'((c % cpu_div) == 0));
			check_value("vdc_en_o", 32'(vdc_en_o), 32'((c % vdc_div) == 0));
		end
	endtask

	task automatic download(input vp_pkg::load_index_e index, input int count);
		logic [7:0] data;
		@(negedge clk_sys);
		dl_index_i  = index;
		dl_active_i = 1'b1; // Idle cycle so the start edge is seen
		for (int a = 0; a < count; a++) begin
			data = 8'(rand_bits(8));
			@(negedge clk_sys);
			dl_wr_i   = 1'b1;
			dl_addr_i = 14'(a);
			dl_data_i = data;
			if (index != vp_pkg::LOAD_FONT)
				rom_model[a] = data;
		end
		@(negedge clk_sys);
		dl_wr_i     = 1'b0;
		dl_active_i = 1'b0;
	endtask

	task automatic check_reads(input vp_pkg::cart_map_e mode, input int count);
		int   addr;
		logic b0;
		logic b1;
		logic [7:0] expected;
		for (int n = 0; n < count; n++) begin
			addr     = int'(rand_bits(12));
			b0       = 1'(n);
			b1       = 1'(n >> 1);
			expected = rom_model[mapped_addr(mode, addr, b0, b1)];
			@(negedge clk_sys);
			cart_addr_i  = 12'(addr);
			cart_bank0_i = b0;
			cart_bank1_i = b1;
			cart_rd_n_i  = 1'b0;
			@(negedge clk_sys);
			cart_rd_n_i = 1'b1;
			cart_addr_i = ~cart_addr_i; // Must not disturb the held byte
			check_value("cart_data_o", 32'(cart_data_o), 32'(expected));
			@(negedge clk_sys);
			check_value("cart_data_o", 32'(cart_data_o), 32'(expected));
		end
	endtask

	task automatic check_key(input logic [8:0] code, input logic pressed,
		input logic [7:0] ascii);
		@(negedge clk_sys);
		check_value("key_valid_o", 32'(key_valid_o), 32'd0);
		ps2_key_i = {~ps2_key_i[10], pressed, code};
		@(negedge clk_sys);
		check_value("key_valid_o", 32'(key_valid_o), 32'd1);
		check_value("key_ascii_o", 32'(key_ascii_o), 32'(ascii));
		check_value("key_released_o", 32'(key_released_o), 32'(!pressed));
		@(negedge clk_sys);
		check_value("key_valid_o", 32'(key_valid_o), 32'd0);
	endtask

	task automatic check_numpad(input logic [9:0] pad0, input logic [9:0] pad1,
		input logic [7:0] ascii, input logic released);
		@(negedge clk_sys);
		joystick_0_i = {pad0, 6'b000000};
		joystick_1_i = {pad1, 6'b000000};
		@(negedge clk_sys);
		check_value("key_valid_o", 32'(key_valid_o), 32'd1);
		check_value("key_ascii_o", 32'(key_ascii_o), 32'(ascii));
		check_value("key_released_o", 32'(key_released_o), 32'(released));
		@(negedge clk_sys);
		check_value("key_valid_o", 32'(key_valid_o), 32'd0);
	endtask

	task automatic check_joy_lines(input int rounds);
		logic [15:0] j0;
		logic [15:0] j1;
		logic [15:0] pa;
		logic [15:0] pb;
		logic        swap;
		for (int n = 0; n < rounds; n++) begin
			j0   = (n == 0) ? 16'h0020 : rand_bits(6); // Both reset on the first round
			j1   = (n == 0) ? 16'h0020 : rand_bits(6);
			swap = 1'(n);
			pa   = swap ? j1 : j0;
			pb   = swap ? j0 : j1;
			@(negedge clk_sys);
			joystick_0_i = j0;
			joystick_1_i = j1;
			joy_swap_i   = swap;
			@(posedge clk_sys);
			check_value("joy_right_n_o", 32'(joy_right_n_o), 32'({~pa[0], ~pb[0]}));
			check_value("joy_left_n_o", 32'(joy_left_n_o), 32'({~pa[1], ~pb[1]}));
			check_value("joy_down_n_o", 32'(joy_down_n_o), 32'({~pa[2], ~pb[2]}));
			check_value("joy_up_n_o", 32'(joy_up_n_o), 32'({~pa[3], ~pb[3]}));
			check_value("joy_action_n_o", 32'(joy_action_n_o), 32'({~pa[4], ~pb[4]}));
			check_value("joy_reset_n_o", 32'(joy_reset_n_o), 32'(!(pa[5] && pb[5])));
		end
	endtask

	task automatic check_palette(input logic pal);
		for (int i = 0; i < 16; i++) begin
			@(negedge clk_sys);
			palette_pal_i = pal;
			rgbl_i        = 4'(i);
			@(negedge clk_sys);
			check_value("color_o", 32'(color_o), 32'(pal ? PAL_COLORS[i] : NTSC_COLORS[i]));
		end
	endtask

	initial begin
		lfsr_state    = 32'hf2cf_4da3;
		reset         = 1'b1;
		pal_i         = 1'b0;
		palette_pal_i = 1'b0;
		dl_active_i   = 1'b0;
		dl_wr_i       = 1'b0;
		dl_index_i    = vp_pkg::LOAD_CART;
		dl_addr_i     = '0;
		dl_data_i     = '0;
		cart_addr_i   = '0;
		cart_bank0_i  = 1'b0;
		cart_bank1_i  = 1'b0;
		cart_rd_n_i   = 1'b1;
		ps2_key_i     = '0;
		joystick_0_i  = '0;
		joystick_1_i  = '0;
		joy_swap_i    = 1'b0;
		rgbl_i        = '0;

		test_enables(1'b0, 8, 6);
		test_enables(1'b1, 12, 10);

		download(vp_pkg::LOAD_CART, 4096);
		check_reads(vp_pkg::MAP_4K, 64);
		download(vp_pkg::LOAD_CART, 8192);
		check_reads(vp_pkg::MAP_8K, 64);
		download(vp_pkg::LOAD_CART_ALT, 16384);
		check_reads(vp_pkg::MAP_16K, 64);
		download(vp_pkg::LOAD_XROM, 4096);
		check_reads(vp_pkg::MAP_XROM, 64);
		download(vp_pkg::LOAD_FONT, 256); // Small size falls back to 2K mapping
		check_reads(vp_pkg::MAP_2K, 64);

		check_key(9'h016, 1'b1, "1");
		check_key(9'h045, 1'b0, "0");
		check_key(9'h01c, 1'b1, "a");
		check_key(9'h01a, 1'b1, "z");
		check_key(9'h029, 1'b1, " ");
		check_key(9'h05a, 1'b1, 8'd10);
		check_key(9'h066, 1'b0, 8'd8);
		check_key(9'h01f, 1'b1, 8'h11);
		check_key(9'h14a, 1'b1, "/"); // Extended code
		check_key(9'h00e, 1'b1, 8'h00);
		check_key(9'h055, 1'b0, "=");

		check_numpad(10'b0000000001, 10'b0000000000, "1", 1'b0);
		check_numpad(10'b0000000100, 10'b0001000000, "3", 1'b0);
		check_numpad(10'b0100000000, 10'b0000000000, "9", 1'b0);
		check_numpad(10'b0000000000, 10'b1000000000, "0", 1'b0);
		check_numpad(10'b0000000000, 10'b0000000000, "0", 1'b1);
		check_joy_lines(16);

		check_palette(1'b0);
		check_palette(1'b1);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* logic/cart_loader.sv */
`timescale 1ns/1ps

module cart_loader (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       dl_active_i,
	input  logic                       dl_wr_i,
	input  vp_pkg::load_index_e        dl_index_i,
	input  logic [vp_pkg::DL_AW-1:0]   dl_addr_i,
	input  logic [7:0]                 dl_data_i,
	input  logic [vp_pkg::CART_AW-1:0] cart_addr_i,
	input  logic                       cart_bank0_i,
	input  logic                       cart_bank1_i,
	input  logic                       cart_rd_n_i,
	output logic [7:0]                 cart_data_o
);

	logic                       dl_active_q;
	logic                       xrom;
	vp_pkg::cart_size_t         cart_size;
	vp_pkg::cart_map_e          map_mode;
	logic [vp_pkg::ROM_AW-1:0]  rd_addr;
	logic                       rom_we;

	logic [7:0] rom_mem [0:(1 << vp_pkg::ROM_AW)-1];

	// Font downloads go elsewhere
	assign rom_we = dl_active_i & dl_wr_i & (dl_index_i < vp_pkg::LOAD_FONT);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			xrom        <= 1'b0;
			cart_size   <= '0;
		end else begin
			dl_active_q <= dl_active_i;
			if (dl_active_i & ~dl_active_q) begin // New download starts
				cart_size <= '0;
				xrom      <= (dl_index_i == vp_pkg::LOAD_XROM);
			end else if (dl_active_i & dl_wr_i) begin
				cart_size <= cart_size + vp_pkg::cart_size_t'(1);
			end
		end
	end

	// Image size picks the banking scheme
	always_comb begin
		if (xrom) begin
			map_mode = vp_pkg::MAP_XROM;
		end else begin
			case (cart_size)
				vp_pkg::SIZE_4K:  map_mode = vp_pkg::MAP_4K;
				vp_pkg::SIZE_8K:  map_mode = vp_pkg::MAP_8K;
				vp_pkg::SIZE_16K: map_mode = vp_pkg::MAP_16K;
				default:          map_mode = vp_pkg::MAP_2K;
			endcase
		end
	end

	// A10 only reaches the ROM on 16K and XROM images
	always_comb begin
		case (map_mode)
			vp_pkg::MAP_XROM: rd_addr = {2'b00, cart_addr_i};
			vp_pkg::MAP_4K:   rd_addr = {2'b00, cart_bank0_i, cart_addr_i[11], cart_addr_i[9:0]};
			vp_pkg::MAP_8K:   rd_addr = {1'b0, cart_bank1_i, cart_bank0_i, cart_addr_i[11],
				cart_addr_i[9:0]};
			vp_pkg::MAP_16K:  rd_addr = {cart_bank1_i, cart_bank0_i, cart_addr_i};
			default:          rd_addr = {3'b000, cart_addr_i[11], cart_addr_i[9:0]};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rom_we)
			rom_mem[dl_addr_i] <= dl_data_i;
		if (!cart_rd_n_i)
			cart_data_o <= rom_mem[rd_addr]; // Holds while PSEN is high
	end

endmodule

/* logic/clock_enable_gen.sv */
`timescale 1ns/1ps

module clock_enable_gen (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	vp_pkg::div_cnt_t cpu_cnt;
	vp_pkg::div_cnt_t vdc_cnt;
	vp_pkg::div_cnt_t cpu_last;
	vp_pkg::div_cnt_t vdc_last;

	// Terminal counts for the selected standard
	assign cpu_last = (pal_i ? vp_pkg::CPU_DIV_PAL : vp_pkg::CPU_DIV_NTSC)
		- vp_pkg::div_cnt_t'(1);
	assign vdc_last = (pal_i ? vp_pkg::VDC_DIV_PAL : vp_pkg::VDC_DIV_NTSC)
		- vp_pkg::div_cnt_t'(1);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt  <= '0;
			vdc_cnt  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			// >= so a PAL to NTSC switch cannot strand the counter
			if (cpu_cnt >= cpu_last) begin
				cpu_cnt  <= '0;
				cpu_en_o <= 1'b1;
			end else begin
				cpu_cnt  <= cpu_cnt + vp_pkg::div_cnt_t'(1);
				cpu_en_o <= 1'b0;
			end

			if (vdc_cnt >= vdc_last) begin
				vdc_cnt  <= '0;
				vdc_en_o <= 1'b1; // Also the pixel enable
			end else begin
				vdc_cnt  <= vdc_cnt + vp_pkg::div_cnt_t'(1);
				vdc_en_o <= 1'b0;
			end
		end
	end

endmodule

/* logic/input_mapper.sv */
`timescale 1ns/1ps

module input_mapper (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic [10:0]  ps2_key_i,
	input  vp_pkg::joy_t joystick_0_i,
	input  vp_pkg::joy_t joystick_1_i,
	input  logic         joy_swap_i,
	output logic         key_valid_o,
	output logic [7:0]   key_ascii_o,
	output logic         key_released_o,
	output logic [1:0]   joy_up_n_o,
	output logic [1:0]   joy_down_n_o,
	output logic [1:0]   joy_left_n_o,
	output logic [1:0]   joy_right_n_o,
	output logic [1:0]   joy_action_n_o,
	output logic         joy_reset_n_o
);

	vp_pkg::joy_t                pad_a;
	vp_pkg::joy_t                pad_b;
	logic [vp_pkg::NUMPAD_W-1:0] numpad;
	logic [vp_pkg::NUMPAD_W-1:0] numpad_q;
	logic                        ps2_toggle_q;
	logic                        ps2_event;
	logic                        pad_event;
	logic                        ps2_released;
	logic                        pad_released;
	logic [7:0]                  ps2_xlat;
	logic [7:0]                  ps2_ascii;
	logic [7:0]                  pad_xlat;
	logic [7:0]                  pad_ascii;

	assign numpad = joystick_0_i.numpad | joystick_1_i.numpad;

	////////////////////////////////////////////////////////////////////////////
	// Scancode to ASCII with the extended bit ignored

	always_comb begin
		case (ps2_key_i[7:0])
			8'h16: ps2_xlat = "1";
			8'h1e: ps2_xlat = "2";
			8'h26: ps2_xlat = "3";
			8'h25: ps2_xlat = "4";
			8'h2e: ps2_xlat = "5";
			8'h36: ps2_xlat = "6";
			8'h3d: ps2_xlat = "7";
			8'h3e: ps2_xlat = "8";
			8'h46: ps2_xlat = "9";
			8'h45: ps2_xlat = "0";
			8'h1c: ps2_xlat = "a";
			8'h32: ps2_xlat = "b";
			8'h21: ps2_xlat = "c";
			8'h23: ps2_xlat = "d";
			8'h24: ps2_xlat = "e";
			8'h2b: ps2_xlat = "f";
			8'h34: ps2_xlat = "g";
			8'h33: ps2_xlat = "h";
			8'h43: ps2_xlat = "i";
			8'h3b: ps2_xlat = "j";
			8'h42: ps2_xlat = "k";
			8'h4b: ps2_xlat = "l";
			8'h3a: ps2_xlat = "m";
			8'h31: ps2_xlat = "n";
			8'h44: ps2_xlat = "o";
			8'h4d: ps2_xlat = "p";
			8'h15: ps2_xlat = "q";
			8'h2d: ps2_xlat = "r";
			8'h1b: ps2_xlat = "s";
			8'h2c: ps2_xlat = "t";
			8'h3c: ps2_xlat = "u";
			8'h2a: ps2_xlat = "v";
			8'h1d: ps2_xlat = "w";
			8'h22: ps2_xlat = "x";
			8'h35: ps2_xlat = "y";
			8'h1a: ps2_xlat = "z";
			8'h29: ps2_xlat = " ";
			8'h79: ps2_xlat = "+";
			8'h7b: ps2_xlat = "-";
			8'h7c: ps2_xlat = "*";
			8'h4a: ps2_xlat = "/";
			8'h55: ps2_xlat = "=";
			8'h1f: ps2_xlat = 8'h11; // Left GUI is "yes"
			8'h27: ps2_xlat = 8'h12; // Right GUI is "no"
			8'h5a: ps2_xlat = 8'd10; // Enter
			8'h66: ps2_xlat = 8'd8;  // Backspace
			default: ps2_xlat = 8'h00;
		endcase
	end

	// Lowest numpad bit wins
	always_comb begin
		pad_xlat = 8'h00;
		for (int i = vp_pkg::NUMPAD_W - 1; i >= 0; i--) begin
			if (numpad[i])
				pad_xlat = (i == vp_pkg::NUMPAD_W - 1) ? "0" : 8'("1" + i);
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ps2_toggle_q <= 1'b0;
			numpad_q     <= '0;
			ps2_event    <= 1'b0;
			pad_event    <= 1'b0;
		end else begin
			ps2_toggle_q <= ps2_key_i[10];
			numpad_q     <= numpad;
			ps2_event    <= (ps2_key_i[10] != ps2_toggle_q);
			pad_event    <= (numpad != numpad_q);
		end
	end

	always_ff @(posedge clk_sys) begin
		ps2_released <= ~ps2_key_i[9];
		pad_released <= ~|numpad;
		if (ps2_key_i[10] != ps2_toggle_q)
			ps2_ascii <= ps2_xlat;
		if (|numpad)
			pad_ascii <= pad_xlat; // Last key stays after release
	end

	assign key_valid_o    = ps2_event | pad_event;
	assign key_ascii_o    = ps2_event ? ps2_ascii : pad_ascii;
	assign key_released_o = ps2_released & pad_released;

	////////////////////////////////////////////////////////////////////////////
	// Joystick lines go low when pressed

	assign pad_a = joy_swap_i ? joystick_1_i : joystick_0_i;
	assign pad_b = joy_swap_i ? joystick_0_i : joystick_1_i;

	assign joy_up_n_o     = ~{pad_a.up, pad_b.up};
	assign joy_down_n_o   = ~{pad_a.down, pad_b.down};
	assign joy_left_n_o   = ~{pad_a.left, pad_b.left};
	assign joy_right_n_o  = ~{pad_a.right, pad_b.right};
	assign joy_action_n_o = ~{pad_a.action, pad_b.action};
	assign joy_reset_n_o  = ~(pad_a.reset & pad_b.reset); // Needs both pads

endmodule

/* logic/palette_lut.sv */
`timescale 1ns/1ps

module palette_lut (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        palette_pal_i,
	input  logic [3:0]  rgbl_i,
	output logic [23:0] color_o
);

	// Calibrated NTSC levels indexed by {R, G, B, luma}
	localparam logic [23:0] NTSC_LUT [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};

	// Plain RGB levels for the PAL machines
	localparam logic [23:0] PAL_LUT [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			color_o <= '0;
		end else if (palette_pal_i) begin
			color_o <= PAL_LUT[rgbl_i];
		end else begin
			color_o <= NTSC_LUT[rgbl_i];
		end
	end

endmodule

/* logic/vp_pkg.sv */
package vp_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Clock enable dividers

	localparam int DIV_CNT_W = 4;

	typedef logic [DIV_CNT_W-1:0] div_cnt_t;

	localparam div_cnt_t CPU_DIV_NTSC = div_cnt_t'(8);  // 42.95 MHz / 8
	localparam div_cnt_t CPU_DIV_PAL  = div_cnt_t'(12); // 70.94 MHz / 12
	localparam div_cnt_t VDC_DIV_NTSC = div_cnt_t'(6);
	localparam div_cnt_t VDC_DIV_PAL  = div_cnt_t'(10);

	////////////////////////////////////////////////////////////////////////////
	// Cartridge memory

	localparam int CART_AW = 12; // Console side address
	localparam int ROM_AW  = 14; // 16 KiB
	localparam int DL_AW   = 14;
	localparam int SIZE_W  = 16;

	typedef logic [SIZE_W-1:0] cart_size_t;

	localparam cart_size_t SIZE_4K  = cart_size_t'(4096);
	localparam cart_size_t SIZE_8K  = cart_size_t'(8192);
	localparam cart_size_t SIZE_16K = cart_size_t'(16384);

	typedef enum logic [1:0] {
		LOAD_CART     = 2'd0,
		LOAD_CART_ALT = 2'd1,
		LOAD_XROM     = 2'd2,
		LOAD_FONT     = 2'd3 // Not stored in the cartridge ROM
	} load_index_e;

	typedef enum logic [2:0] {
		MAP_2K,
		MAP_4K,
		MAP_8K,
		MAP_16K,
		MAP_XROM
	} cart_map_e;

	////////////////////////////////////////////////////////////////////////////
	// Joystick word from the host

	localparam int NUMPAD_W = 10;

	typedef struct packed {
		logic [NUMPAD_W-1:0] numpad; // Keys 1 to 9, then 0
		logic                reset;
		logic                action;
		logic                up;
		logic                down;
		logic                left;
		logic                right;  // Bit 0
	} joy_t;

endpackage

/* logic/vp_support_top.sv */
`timescale 1ns/1ps

module vp_support_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       pal_i,
	input  logic                       palette_pal_i,
	input  logic                       dl_active_i,
	input  logic                       dl_wr_i,
	input  vp_pkg::load_index_e        dl_index_i,
	input  logic [vp_pkg::DL_AW-1:0]   dl_addr_i,
	input  logic [7:0]                 dl_data_i,
	input  logic [vp_pkg::CART_AW-1:0] cart_addr_i,
	input  logic                       cart_bank0_i,
	input  logic                       cart_bank1_i,
	input  logic                       cart_rd_n_i,
	input  logic [10:0]                ps2_key_i,
	input  vp_pkg::joy_t               joystick_0_i,
	input  vp_pkg::joy_t               joystick_1_i,
	input  logic                       joy_swap_i,
	input  logic [3:0]                 rgbl_i,
	output logic                       cpu_en_o,
	output logic                       vdc_en_o,
	output logic [7:0]                 cart_data_o,
	output logic                       key_valid_o,
	output logic [7:0]                 key_ascii_o,
	output logic                       key_released_o,
	output logic [1:0]                 joy_up_n_o,
	output logic [1:0]                 joy_down_n_o,
	output logic [1:0]                 joy_left_n_o,
	output logic [1:0]                 joy_right_n_o,
	output logic [1:0]                 joy_action_n_o,
	output logic                       joy_reset_n_o,
	output logic [23:0]                color_o
);

	////////////////////////////////////////////////////////////////////////////
	// CPU and VDC timing

	clock_enable_gen clock_enable_gen_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Cartridge ROM

	cart_loader cart_loader_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active_i  (dl_active_i),
		.dl_wr_i      (dl_wr_i),
		.dl_index_i   (dl_index_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.cart_addr_i  (cart_addr_i),
		.cart_bank0_i (cart_bank0_i),
		.cart_bank1_i (cart_bank1_i),
		.cart_rd_n_i  (cart_rd_n_i),
		.cart_data_o  (cart_data_o)
	);

	input_mapper input_mapper_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ps2_key_i      (ps2_key_i),
		.joystick_0_i   (joystick_0_i),
		.joystick_1_i   (joystick_1_i),
		.joy_swap_i     (joy_swap_i),
		.key_valid_o    (key_valid_o),
		.key_ascii_o    (key_ascii_o),
		.key_released_o (key_released_o),
		.joy_up_n_o     (joy_up_n_o),     // Bit 1 is the first pad
		.joy_down_n_o   (joy_down_n_o),
		.joy_left_n_o   (joy_left_n_o),
		.joy_right_n_o  (joy_right_n_o),
		.joy_action_n_o (joy_action_n_o),
		.joy_reset_n_o  (joy_reset_n_o)
	);

	palette_lut palette_lut_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.palette_pal_i (palette_pal_i),
		.rgbl_i        (rgbl_i),
		.color_o       (color_o)
	);

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 -f verilog.f --top-module tb_vp_support \
	-o sim_vp_support > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_vp_support > sim.log 2>&1
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1 || exit 0

/* verilog.f */
logic/vp_pkg.sv
logic/clock_enable_gen.sv
logic/cart_loader.sv
logic/input_mapper.sv
logic/palette_lut.sv
logic/vp_support_top.sv
dv/tb_vp_support.sv
